// ==== Bender.yml ====
package:
  name: vector_ldst_unit

sources:
  - files:
      - hdl/ldst_pkg.sv
      - hdl/mem_port_if.sv
      - hdl/ldst_channel.sv
      - hdl/vector_ldst_unit.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/ldst_asserts.sv
      - bench/ldst_checker.sv
      - bench/tb_vector_ldst_unit.sv

// ==== bench/ldst_asserts.sv ====
/*
 * Concurrent assertions bound to the load/store unit
 * Reset state, memory handshake stability and commit hold
 */
`timescale 1ns/1ps
`default_nettype none

module ldst_asserts (
	input logic clock,
	input logic rst_n,
	input logic ld_req, ld_grant, ld_end,
	input logic st_req, st_grant, st_end,
	input ldst_pkg::address_t ld_len, ld_stride, ld_base,
	input ldst_pkg::address_t st_len, st_stride, st_base,
	input logic wb_valid, commit_valid, commit_grant
);

	reset_idle: assert property (@(posedge clock) !rst_n |-> !ld_req && !st_req
		&& !wb_valid && !commit_valid) else $error("Outputs active in reset");

	ld_fields_stable: assert property (@(posedge clock) disable iff (!rst_n)
		ld_req && !ld_end |=> $stable({ld_len, ld_stride, ld_base}))
		else $error("Load request fields changed");

	st_fields_stable: assert property (@(posedge clock) disable iff (!rst_n)
		st_req && !st_end |=> $stable({st_len, st_stride, st_base}))
		else $error("Store request fields changed");

	ld_grant_req: assert property (@(posedge clock) disable iff (!rst_n)
		ld_grant |-> ld_req) else $error("Load grant without request");

	st_grant_req: assert property (@(posedge clock) disable iff (!rst_n)
		st_grant |-> st_req) else $error("Store grant without request");

	commit_hold: assert property (@(posedge clock) disable iff (!rst_n)
		commit_valid && !commit_grant |=> commit_valid)
		else $error("Commit token dropped before grant");

endmodule

`default_nettype wire

// ==== bench/ldst_checker.sv ====
/*
 * Load/store unit checker
 * Builds reference queues from the command table, compares
 * descriptors, data and commit tokens cycle by cycle
 */
`timescale 1ns/1ps
`default_nettype none

module ldst_checker #(
	parameter int         N_CMD   = 12,
	parameter int         ENTRY_W = 39,
	parameter logic [7:0] ISSUE0  = 8'h00
) (
	input  logic clock,
	input  logic rst_n,
	input  logic [N_CMD-1:0][ENTRY_W-1:0] cmd_table,
	input  logic ld_req, ld_end, st_req, st_end, st_grant, st_push,
	input  ldst_pkg::address_t ld_len, ld_stride, ld_base,
	input  ldst_pkg::address_t st_len, st_stride, st_base,
	input  ldst_pkg::data_t st_data, st_push_data, wb_data,
	input  logic wb_valid, ld_stall, st_stall,
	input  logic commit_valid, commit_is_store, commit_grant,
	input  ldst_pkg::issue_no_t commit_issue_no,
	input  ldst_pkg::dst_t commit_dst,
	output logic done
);

	logic [29:0] ld_desc_q[$], st_desc_q[$];	// {len, stride, base}
	int ld_iss_q[$], st_iss_q[$];			// Table rows awaiting end
	int ld_tok_q[$], st_tok_q[$];			// Model of waiting tokens
	int ld_rdy_q[$], st_rdy_q[$];
	ldst_pkg::data_t wb_q[$], st_word_q[$];
	bit committed[N_CMD];
	int checks[1:6], errs[1:6];
	int err_total, n_mem, commit_cnt, cyc;
	bit built, reset_checked, stall_seen;
	logic ld_req_d, ld_end_d, st_req_d, st_end_d;

	task automatic err_value(input int b, input string sig, input logic [31:0] exp,
		input logic [31:0] got);
		$display("ERR %0t %s expected %h got %h", $time, sig, exp, got);
		errs[b]++;
		err_total++;
	endtask

	task automatic err_text(input int b, input string what);
		$display("Error at %0t: %s", $time, what);
		errs[b]++;
		err_total++;
	endtask

	task automatic build();
		logic [ENTRY_W-1:0] e;
		for (int i = 0; i < N_CMD; i++) begin
			e = cmd_table[i];
			if (e[37:36] != ldst_pkg::OP_TYPE_MEM)
				continue;
			n_mem++;
			if (e[35] == ldst_pkg::CLASS_LD) begin
				ld_desc_q.push_back(e[29:0]);
				ld_iss_q.push_back(i);
				for (int j = 0; j < e[29:20]; j++)
					wb_q.push_back(ldst_pkg::data_t'(e[9:0]) + j);
			end else begin
				st_desc_q.push_back(e[29:0]);
				st_iss_q.push_back(i);
			end
		end
		built = 1'b1;
	endtask

	task automatic check_commit();
		bit ld_rdy, st_rdy, pick_st;
		ldst_pkg::issue_no_t exp_iss;
		int row;
		ld_rdy = ld_tok_q.size() > 0 && ld_rdy_q[0] <= cyc;
		st_rdy = st_tok_q.size() > 0 && st_rdy_q[0] <= cyc;
		checks[5]++;
		if (commit_valid !== (ld_rdy | st_rdy)) begin
			err_value(5, "commit_valid", ld_rdy | st_rdy, commit_valid);
			return;
		end
		if (!commit_valid)
			return;
		// Older token comes from the earlier table row
		pick_st = st_rdy && (!ld_rdy || st_tok_q[0] < ld_tok_q[0]);
		row     = pick_st ? st_tok_q[0] : ld_tok_q[0];
		exp_iss = ldst_pkg::issue_no_t'(ISSUE0 + row);
		if (commit_issue_no !== exp_iss)
			err_value(5, "commit_issue_no", exp_iss, commit_issue_no);
		if (commit_is_store !== pick_st)
			err_value(5, "commit_is_store", pick_st, commit_is_store);
		if (!commit_grant)
			return;
		if (pick_st) begin
			void'(st_tok_q.pop_front());
			void'(st_rdy_q.pop_front());
		end else begin
			void'(ld_tok_q.pop_front());
			void'(ld_rdy_q.pop_front());
		end
		if (committed[row])
			err_text(5, $sformatf("issue %0d committed twice", exp_iss));
		committed[row] = 1'b1;
		commit_cnt++;
		if (commit_dst !== cmd_table[row][34:30])
			err_value(5, "commit_dst", cmd_table[row][34:30], commit_dst);
	endtask

	always @(posedge clock) begin
		if (!rst_n) begin
			ld_req_d <= 1'b0;
			st_req_d <= 1'b0;
			ld_end_d <= 1'b0;
			st_end_d <= 1'b0;
			done     <= 1'b0;
		end else begin
			if (!built)
				build();
			cyc++;
			if (!reset_checked) begin
				checks[1]++;
				if ({ld_req, st_req, wb_valid, commit_valid, ld_stall, st_stall} !== '0)
					err_text(1, "outputs not idle after reset");
				reset_checked = 1'b1;
			end

			// New descriptors on each port
			if (ld_req && (!ld_req_d || ld_end_d)) begin
				checks[2]++;
				if (ld_desc_q.size() == 0)
					err_text(1, "unexpected load request");
				else if ({ld_len, ld_stride, ld_base} !== ld_desc_q.pop_front())
					err_text(2, $sformatf("load descriptor %h/%h/%h out of order",
						ld_len, ld_stride, ld_base));
			end
			if (st_req && (!st_req_d || st_end_d)) begin
				checks[2]++;
				if (st_desc_q.size() == 0)
					err_text(1, "unexpected store request");
				else if ({st_len, st_stride, st_base} !== st_desc_q.pop_front())
					err_text(2, $sformatf("store descriptor %h/%h/%h out of order",
						st_len, st_stride, st_base));
			end

			// Ends become tokens two cycles later
			if (ld_end) begin
				if (ld_iss_q.size() == 0)
					err_text(5, "load end without a command");
				else begin
					ld_tok_q.push_back(ld_iss_q.pop_front());
					ld_rdy_q.push_back(cyc + 2);
				end
			end
			if (st_end) begin
				if (st_iss_q.size() == 0)
					err_text(5, "store end without a command");
				else begin
					st_tok_q.push_back(st_iss_q.pop_front());
					st_rdy_q.push_back(cyc + 2);
				end
			end

			if (wb_valid) begin
				checks[3]++;
				if (wb_q.size() == 0)
					err_text(3, "extra write-back word");
				else if (wb_data !== wb_q[0])
					err_value(3, "wb_data", wb_q.pop_front(), wb_data);
				else
					void'(wb_q.pop_front());
			end

			if (st_grant) begin
				checks[4]++;
				if (st_word_q.size() == 0)
					err_text(4, "store grant with no pushed word");
				else if (st_data !== st_word_q[0])
					err_value(4, "st_data", st_word_q.pop_front(), st_data);
				else
					void'(st_word_q.pop_front());
			end
			if (st_push)
				st_word_q.push_back(st_push_data);

			check_commit();
			if (ld_stall)
				stall_seen = 1'b1;

			ld_req_d <= ld_req;
			st_req_d <= st_req;
			ld_end_d <= ld_end;
			st_end_d <= st_end;
			done     <= (commit_cnt == n_mem) && (wb_q.size() == 0);
		end
	end

	task automatic report();
		string names[1:6];
		names[1] = "reset state and decode";
		names[2] = "descriptor order";
		names[3] = "load write-back data";
		names[4] = "store data order";
		names[5] = "commit order and tokens";
		names[6] = "load stall and recovery";
		if (ld_desc_q.size() != 0 || st_desc_q.size() != 0)
			err_text(2, "descriptors never requested");
		if (wb_q.size() != 0)
			err_text(3, "load words missing");
		if (st_word_q.size() != 0)
			err_text(4, "pushed store words never taken");
		if (commit_cnt != n_mem)
			err_text(5, "not every memory command committed");
		checks[6]++;
		if (!stall_seen)
			err_text(6, "ld_stall never rose during the load burst");
		for (int b = 1; b <= 6; b++)
			$display("Test %0d %s: %0d checks, %0d errors", b, names[b], checks[b], errs[b]);
		$display("Totals: %0d commits, %0d errors", commit_cnt, err_total);
	endtask

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 40 ns clock, rst_n held low for the first 16 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic rst_n
);

	localparam time HALF_PERIOD  = 20ns;
	localparam int  RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 rst_n = 1'b1;	// Clear of the edge
	end

endmodule

`default_nettype wire

// ==== bench/tb_vector_ldst_unit.sv ====
/*
 * Testbench top for the vector load/store unit
 * Applies a command table, answers both memory ports,
 * pushes store words and grants commit tokens at random
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vector_ldst_unit;

	localparam int       N_CMD       = 12;
	localparam int       ENTRY_W     = 39;
	localparam logic [7:0] ISSUE0    = 8'hF8;	// Issue numbers wrap mid-table
	localparam int       WAIT_LIMIT  = 200;
	localparam int       DONE_LIMIT  = 3000;

	logic clock;
	logic rst_n;
	logic cmd_valid;
	ldst_pkg::op_type_t cmd_op_type;
	logic cmd_class;
	ldst_pkg::dst_t cmd_dst;
	ldst_pkg::issue_no_t cmd_issue_no;
	ldst_pkg::issue_no_t cur_issue_no;
	ldst_pkg::data_t src_data1;
	ldst_pkg::data_t src_data2;
	ldst_pkg::data_t src_data3;
	logic I_stall;
	logic ld_req, ld_grant, ld_end;
	ldst_pkg::address_t ld_len, ld_stride, ld_base;
	ldst_pkg::data_t ld_data;
	logic st_req, st_grant, st_end;
	ldst_pkg::address_t st_len, st_stride, st_base;
	ldst_pkg::data_t st_data;
	logic st_push;
	ldst_pkg::data_t st_push_data;
	logic wb_valid;
	ldst_pkg::data_t wb_data;
	logic ld_stall, st_stall;
	logic commit_valid, commit_is_store, commit_grant;
	ldst_pkg::issue_no_t commit_issue_no;
	ldst_pkg::dst_t commit_dst;
	logic hold_off;				// Load responder held back
	logic check_done;

	// Row: {hold, op, class, dst, len, stride, base}
	logic [N_CMD-1:0][ENTRY_W-1:0] cmd_table;

	initial begin
		cmd_table[0]  = {1'b0, 2'b11, 1'b0, 5'd1,  10'd3, 10'd1, 10'h010};
		cmd_table[1]  = {1'b0, 2'b01, 1'b0, 5'd7,  10'd2, 10'd1, 10'h3F0};	// Not memory
		cmd_table[2]  = {1'b0, 2'b11, 1'b1, 5'd2,  10'd2, 10'd2, 10'h100};
		cmd_table[3]  = {1'b0, 2'b11, 1'b0, 5'd3,  10'd4, 10'd1, 10'h020};
		cmd_table[4]  = {1'b0, 2'b11, 1'b1, 5'd4,  10'd3, 10'd4, 10'h140};
		cmd_table[5]  = {1'b0, 2'b00, 1'b1, 5'd9,  10'd1, 10'd1, 10'h3E0};	// Not memory
		cmd_table[6]  = {1'b0, 2'b11, 1'b1, 5'd5,  10'd1, 10'd1, 10'h180};
		cmd_table[7]  = {1'b1, 2'b11, 1'b0, 5'd10, 10'd2, 10'd1, 10'h200};	// Burst starts
		cmd_table[8]  = {1'b0, 2'b11, 1'b0, 5'd11, 10'd2, 10'd3, 10'h210};
		cmd_table[9]  = {1'b0, 2'b11, 1'b0, 5'd12, 10'd2, 10'd1, 10'h220};
		cmd_table[10] = {1'b0, 2'b11, 1'b0, 5'd13, 10'd2, 10'd2, 10'h230};
		cmd_table[11] = {1'b0, 2'b11, 1'b0, 5'd14, 10'd2, 10'd1, 10'h240};
	end

	tb_clock_gen clock_gen_inst (.clock(clock), .rst_n(rst_n));

	vector_ldst_unit vector_ldst_unit_inst (.*);

	ldst_checker #(.N_CMD(N_CMD), .ENTRY_W(ENTRY_W), .ISSUE0(ISSUE0)) checker_inst (
		.clock(clock), .rst_n(rst_n), .cmd_table(cmd_table),
		.ld_req(ld_req), .ld_len(ld_len), .ld_stride(ld_stride), .ld_base(ld_base),
		.ld_end(ld_end), .st_req(st_req), .st_len(st_len), .st_stride(st_stride),
		.st_base(st_base), .st_end(st_end), .st_grant(st_grant), .st_data(st_data),
		.st_push(st_push), .st_push_data(st_push_data), .wb_valid(wb_valid),
		.wb_data(wb_data), .ld_stall(ld_stall), .st_stall(st_stall),
		.commit_valid(commit_valid), .commit_issue_no(commit_issue_no),
		.commit_dst(commit_dst), .commit_is_store(commit_is_store),
		.commit_grant(commit_grant), .done(check_done)
	);

	bind vector_ldst_unit ldst_asserts asserts_inst (.*);

	////////////////////
	// Memory responders, 0 to 3 idle cycles before each access
	int unsigned ld_state, ld_wait, ld_beat;
	int unsigned st_state, st_wait, st_beat;

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ld_state <= 0;
			ld_grant <= 1'b0;
			ld_end   <= 1'b0;
			ld_data  <= '0;
		end else begin
			ld_grant <= 1'b0;
			ld_end   <= 1'b0;
			case (ld_state)
				0: if (ld_req && !hold_off) begin
					ld_wait  <= $urandom % 4;
					ld_beat  <= 0;
					ld_state <= 1;
				end
				1: begin
					if (ld_wait == 0)
						ld_state <= 2;
					else
						ld_wait <= ld_wait - 1;
				end
				2: begin
					ld_grant <= 1'b1;
					ld_data  <= ldst_pkg::data_t'(ld_base) + ld_beat;
					ld_end   <= (ld_beat == ld_len - 1);
					ld_beat  <= ld_beat + 1;
					if (ld_beat == ld_len - 1)
						ld_state <= 3;
				end
				default: ld_state <= 0;	// Head pops this cycle
			endcase
		end
	end

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			st_state <= 0;
			st_grant <= 1'b0;
			st_end   <= 1'b0;
		end else begin
			st_grant <= 1'b0;
			st_end   <= 1'b0;
			case (st_state)
				0: if (st_req) begin
					st_wait  <= $urandom % 4;
					st_beat  <= 0;
					st_state <= 1;
				end
				1: begin
					if (st_wait == 0)
						st_state <= 2;
					else
						st_wait <= st_wait - 1;
				end
				2: begin
					st_grant <= 1'b1;
					st_end   <= (st_beat == st_len - 1);
					st_beat  <= st_beat + 1;
					if (st_beat == st_len - 1)
						st_state <= 3;
				end
				default: st_state <= 0;
			endcase
		end
	end

	// Random commit grants and write-back stalls
	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			commit_grant <= 1'b0;
			I_stall      <= 1'b0;
		end else begin
			commit_grant <= commit_valid && ($urandom % 3 != 0);
			I_stall      <= ($urandom % 4 == 0);
		end
	end

	////////////////////
	// Stimulus
	task automatic fail_run(input string what);
		$display("Timeout: %s", what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// Checked at the falling edge, where the stall is settled
	task automatic wait_no_stall(input logic is_store);
		int n;
		n = 0;
		@(negedge clock);
		while (is_store ? st_stall : ld_stall) begin
			if (!is_store && hold_off)
				hold_off <= 1'b0;	// Let the held loads drain
			n++;
			if (n > WAIT_LIMIT)
				fail_run("stall never dropped");
			@(negedge clock);
		end
	endtask

	task automatic push_store_word(input ldst_pkg::data_t word);
		wait_no_stall(1'b1);
		@(posedge clock);
		st_push      <= 1'b1;
		st_push_data <= word;
		@(posedge clock);
		st_push <= 1'b0;
	endtask

	initial begin
		logic [ENTRY_W-1:0] e;
		int n;
		void'($urandom(29));
		cmd_valid    = 1'b0;
		cmd_op_type  = '0;
		cmd_class    = 1'b0;
		cmd_dst      = '0;
		cmd_issue_no = '0;
		cur_issue_no = ISSUE0;
		src_data1    = '0;
		src_data2    = '0;
		src_data3    = '0;
		st_push      = 1'b0;
		st_push_data = '0;
		hold_off     = 1'b0;
		n = 0;
		while (rst_n !== 1'b1) begin
			n++;
			if (n > 100)
				fail_run("reset never released");
			@(posedge clock);
		end
		for (int i = 0; i < N_CMD; i++) begin
			e = cmd_table[i];
			if (e[38])
				hold_off <= 1'b1;
			if (e[37:36] == ldst_pkg::OP_TYPE_MEM && e[35] == ldst_pkg::CLASS_ST) begin
				for (int j = 0; j < e[29:20]; j++)
					push_store_word($urandom);
			end
			wait_no_stall(e[35]);
			@(posedge clock);
			cmd_valid    <= 1'b1;
			cmd_op_type  <= e[37:36];
			cmd_class    <= e[35];
			cmd_dst      <= e[34:30];
			cmd_issue_no <= ISSUE0 + i;
			src_data1    <= ldst_pkg::data_t'(e[29:20]);
			src_data2    <= ldst_pkg::data_t'(e[19:10]);
			src_data3    <= ldst_pkg::data_t'(e[9:0]);
			@(posedge clock);
			cmd_valid    <= 1'b0;
			cur_issue_no <= ISSUE0 + i + 1;
		end
		n = 0;
		while (!check_done) begin
			n++;
			if (n > DONE_LIMIT)
				fail_run("commands did not all complete");
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
		checker_inst.report();
		if (checker_inst.err_total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/ldst_channel.sv ====
/*
 * One load/store channel
 * Queues access descriptors and offers the head to memory,
 * buffers data words in a FIFO and holds a commit token for
 * each finished access until the commit stage takes it
 */
`timescale 1ns/1ps
`default_nettype none

module ldst_channel (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                accept,		// New command for this channel
	input  ldst_pkg::address_t  len,
	input  ldst_pkg::address_t  stride,
	input  ldst_pkg::address_t  base,
	input  ldst_pkg::issue_no_t issue_no,
	input  ldst_pkg::dst_t      dst,
	input  logic                data_push,
	input  ldst_pkg::data_t     push_data,
	input  logic                data_pop,
	output logic                data_avail,
	output ldst_pkg::data_t     pop_data,	// FIFO head
	mem_port_if.channel         mem,
	input  logic                token_grant,
	output logic                token_valid,
	output ldst_pkg::issue_no_t token_issue_no,
	output ldst_pkg::dst_t      token_dst,
	output logic                stall
);

	ldst_pkg::address_t  desc_len      [ldst_pkg::DESC_DEPTH];
	ldst_pkg::address_t  desc_stride   [ldst_pkg::DESC_DEPTH];
	ldst_pkg::address_t  desc_base     [ldst_pkg::DESC_DEPTH];
	ldst_pkg::issue_no_t desc_issue_no [ldst_pkg::DESC_DEPTH];
	ldst_pkg::dst_t      desc_dst      [ldst_pkg::DESC_DEPTH];
	ldst_pkg::desc_ptr_t desc_wr_ptr;
	ldst_pkg::desc_ptr_t desc_rd_ptr;
	logic                desc_empty;
	logic                push_desc;
	logic                pop_desc;

	ldst_pkg::issue_no_t tok_issue_no  [ldst_pkg::DESC_DEPTH];
	ldst_pkg::dst_t      tok_dst       [ldst_pkg::DESC_DEPTH];
	ldst_pkg::desc_ptr_t tok_wr_ptr;
	ldst_pkg::desc_ptr_t tok_rd_ptr;
	logic                pop_tok;
	ldst_pkg::desc_ptr_t slot_cnt;		// Accepted but not yet committed
	logic                slot_full;

	logic                end_q;
	ldst_pkg::issue_no_t end_issue_no_q;
	ldst_pkg::dst_t      end_dst_q;

	ldst_pkg::data_t     data_mem      [ldst_pkg::DATA_DEPTH];
	ldst_pkg::data_ptr_t data_wr_ptr;
	ldst_pkg::data_ptr_t data_rd_ptr;
	logic                data_full;
	logic                do_push;
	logic                do_pop;

	////////////////////
	// Descriptor queue
	assign desc_empty = (desc_wr_ptr == desc_rd_ptr);
	assign push_desc  = accept & ~stall;			// Dropped while stalled
	assign pop_desc   = mem.end_access & ~desc_empty;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			desc_wr_ptr <= '0;
			desc_rd_ptr <= '0;
		end else begin
			if (push_desc)
				desc_wr_ptr <= desc_wr_ptr + 1'b1;
			if (pop_desc)
				desc_rd_ptr <= desc_rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push_desc) begin
			desc_len[desc_wr_ptr[ldst_pkg::DESC_AW-1:0]]      <= len;
			desc_stride[desc_wr_ptr[ldst_pkg::DESC_AW-1:0]]   <= stride;
			desc_base[desc_wr_ptr[ldst_pkg::DESC_AW-1:0]]     <= base;
			desc_issue_no[desc_wr_ptr[ldst_pkg::DESC_AW-1:0]] <= issue_no;
			desc_dst[desc_wr_ptr[ldst_pkg::DESC_AW-1:0]]      <= dst;
		end
	end

	assign mem.req    = ~desc_empty;
	assign mem.len    = desc_len[desc_rd_ptr[ldst_pkg::DESC_AW-1:0]];
	assign mem.stride = desc_stride[desc_rd_ptr[ldst_pkg::DESC_AW-1:0]];
	assign mem.base   = desc_base[desc_rd_ptr[ldst_pkg::DESC_AW-1:0]];

	////////////////////
	// Commit tokens
	// A finished access spends one cycle in the end stage first
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			end_q <= 1'b0;
		else
			end_q <= pop_desc;
	end

	always_ff @(posedge clock) begin
		if (pop_desc) begin
			end_issue_no_q <= desc_issue_no[desc_rd_ptr[ldst_pkg::DESC_AW-1:0]];
			end_dst_q      <= desc_dst[desc_rd_ptr[ldst_pkg::DESC_AW-1:0]];
		end
		if (end_q) begin
			tok_issue_no[tok_wr_ptr[ldst_pkg::DESC_AW-1:0]] <= end_issue_no_q;
			tok_dst[tok_wr_ptr[ldst_pkg::DESC_AW-1:0]]      <= end_dst_q;
		end
	end

	assign token_valid    = (tok_wr_ptr != tok_rd_ptr);
	assign token_issue_no = tok_issue_no[tok_rd_ptr[ldst_pkg::DESC_AW-1:0]];
	assign token_dst      = tok_dst[tok_rd_ptr[ldst_pkg::DESC_AW-1:0]];
	assign pop_tok        = token_grant & token_valid;

	// One slot per command from accept to commit, so
	// neither the descriptor nor the token queue overflows
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			tok_wr_ptr <= '0;
			tok_rd_ptr <= '0;
			slot_cnt   <= '0;
		end else begin
			if (end_q)
				tok_wr_ptr <= tok_wr_ptr + 1'b1;
			if (pop_tok)
				tok_rd_ptr <= tok_rd_ptr + 1'b1;
			if (push_desc && !pop_tok)
				slot_cnt <= slot_cnt + 1'b1;
			else if (pop_tok && !push_desc)
				slot_cnt <= slot_cnt - 1'b1;
		end
	end

	assign slot_full = (slot_cnt == ldst_pkg::desc_ptr_t'(ldst_pkg::DESC_DEPTH));

	////////////////////
	// Data FIFO
	assign data_avail = (data_wr_ptr != data_rd_ptr);
	assign data_full  = (ldst_pkg::data_ptr_t'(data_wr_ptr - data_rd_ptr)
		== ldst_pkg::data_ptr_t'(ldst_pkg::DATA_DEPTH));
	assign do_push    = data_push & ~data_full;
	assign do_pop     = data_pop & data_avail;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			data_wr_ptr <= '0;
			data_rd_ptr <= '0;
		end else begin
			if (do_push)
				data_wr_ptr <= data_wr_ptr + 1'b1;
			if (do_pop)
				data_rd_ptr <= data_rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			data_mem[data_wr_ptr[ldst_pkg::DATA_AW-1:0]] <= push_data;
	end

	assign pop_data    = data_mem[data_rd_ptr[ldst_pkg::DATA_AW-1:0]];
	assign mem.wr_data = pop_data;				// Store side reads the head

	assign stall = slot_full | data_full;

endmodule

`default_nettype wire

// ==== hdl/ldst_pkg.sv ====
/*
 * Load/store unit shared definitions
 * Operand widths, command field encodings and the depths
 * of the descriptor, token and data queues
 */
`default_nettype none

package ldst_pkg;

	////////////////////
	// Field widths
	localparam int DATA_W     = 32;
	localparam int ADDR_W     = 10;	// Length, stride, base
	localparam int ISSUE_NO_W = 8;
	localparam int DST_W      = 5;
	localparam int OP_TYPE_W  = 2;

	////////////////////
	// Queue depths
	localparam int DESC_DEPTH = 4;	// Descriptors and commit tokens
	localparam int DATA_DEPTH = 16;	// Data words per channel
	localparam int DESC_AW    = $clog2(DESC_DEPTH);
	localparam int DATA_AW    = $clog2(DATA_DEPTH);

	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [ADDR_W-1:0]     address_t;
	typedef logic [ISSUE_NO_W-1:0] issue_no_t;	// Wraps around
	typedef logic [DST_W-1:0]      dst_t;
	typedef logic [OP_TYPE_W-1:0]  op_type_t;

	// Pointers carry one extra wrap bit
	typedef logic [DESC_AW:0] desc_ptr_t;
	typedef logic [DATA_AW:0] data_ptr_t;

	////////////////////
	// Command encodings
	localparam op_type_t OP_TYPE_MEM = 2'b11;	// Memory access
	localparam logic CLASS_LD = 1'b0;
	localparam logic CLASS_ST = 1'b1;

endpackage

`default_nettype wire

// ==== hdl/mem_port_if.sv ====
/*
 * Memory-side port of one load/store channel
 * Descriptor request, per-word grant, end of access and data both ways
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if (
	input logic clock
);

	logic               req;		// Level, head descriptor waiting
	ldst_pkg::address_t len;
	ldst_pkg::address_t stride;
	ldst_pkg::address_t base;
	logic               grant;		// One strobe per word
	logic               end_access;	// Last word of the head descriptor
	ldst_pkg::data_t    rd_data;	// Loaded word
	ldst_pkg::data_t    wr_data;	// Word to store

	modport channel (
		input  clock,
		output req, len, stride, base, wr_data,
		input  grant, end_access, rd_data
	);

	modport memory (
		input  clock,
		input  req, len, stride, base, wr_data,
		output grant, end_access, rd_data
	);

endinterface

`default_nettype wire

// ==== hdl/vector_ldst_unit.sv ====
/*
 * Vector engine load/store unit
 * Decodes memory commands into a load and a store channel,
 * forwards loaded words as register write-back and offers
 * the older of the two waiting commit tokens first
 */
`timescale 1ns/1ps
`default_nettype none

module vector_ldst_unit (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                cmd_valid,
	input  ldst_pkg::op_type_t  cmd_op_type,
	input  logic                cmd_class,		// 0 load, 1 store
	input  ldst_pkg::dst_t      cmd_dst,
	input  ldst_pkg::issue_no_t cmd_issue_no,
	input  ldst_pkg::data_t     src_data1,		// Length
	input  ldst_pkg::data_t     src_data2,		// Stride
	input  ldst_pkg::data_t     src_data3,		// Base
	input  ldst_pkg::issue_no_t cur_issue_no,
	input  logic                I_stall,		// Holds write-back
	output logic                ld_req,
	output ldst_pkg::address_t  ld_len,
	output ldst_pkg::address_t  ld_stride,
	output ldst_pkg::address_t  ld_base,
	input  logic                ld_grant,
	input  ldst_pkg::data_t     ld_data,
	input  logic                ld_end,
	output logic                st_req,
	output ldst_pkg::address_t  st_len,
	output ldst_pkg::address_t  st_stride,
	output ldst_pkg::address_t  st_base,
	output ldst_pkg::data_t     st_data,
	input  logic                st_grant,
	input  logic                st_end,
	input  logic                st_push,
	input  ldst_pkg::data_t     st_push_data,
	output logic                wb_valid,
	output ldst_pkg::data_t     wb_data,
	output logic                ld_stall,
	output logic                st_stall,
	output logic                commit_valid,
	output ldst_pkg::issue_no_t commit_issue_no,
	output ldst_pkg::dst_t      commit_dst,
	output logic                commit_is_store,
	input  logic                commit_grant
);

	logic                is_mem;
	logic                ld_accept;
	logic                st_accept;
	logic                ld_avail;
	logic                ld_pop;
	ldst_pkg::data_t     ld_pop_data;
	logic                ld_tok_valid;
	logic                st_tok_valid;
	ldst_pkg::issue_no_t ld_tok_issue_no;
	ldst_pkg::issue_no_t st_tok_issue_no;
	ldst_pkg::dst_t      ld_tok_dst;
	ldst_pkg::dst_t      st_tok_dst;
	ldst_pkg::issue_no_t ld_age;
	ldst_pkg::issue_no_t st_age;
	logic                sel_st;

	mem_port_if ld_mem (.clock(clock));
	mem_port_if st_mem (.clock(clock));

	////////////////////
	// Command decode
	assign is_mem    = cmd_valid & (cmd_op_type == ldst_pkg::OP_TYPE_MEM);
	assign ld_accept = is_mem & (cmd_class == ldst_pkg::CLASS_LD);
	assign st_accept = is_mem & (cmd_class == ldst_pkg::CLASS_ST);

	////////////////////
	// Memory side
	assign ld_mem.grant      = ld_grant;
	assign ld_mem.end_access = ld_end;
	assign ld_mem.rd_data    = ld_data;
	assign ld_req            = ld_mem.req;
	assign ld_len            = ld_mem.len;
	assign ld_stride         = ld_mem.stride;
	assign ld_base           = ld_mem.base;

	assign st_mem.grant      = st_grant;
	assign st_mem.end_access = st_end;
	assign st_mem.rd_data    = '0;			// Store reads nothing back
	assign st_req            = st_mem.req;
	assign st_len            = st_mem.len;
	assign st_stride         = st_mem.stride;
	assign st_base           = st_mem.base;
	assign st_data           = st_mem.wr_data;

	ldst_channel ld_channel (
		.clock          (clock),
		.rst_n          (rst_n),
		.accept         (ld_accept),
		.len            (ldst_pkg::address_t'(src_data1)),
		.stride         (ldst_pkg::address_t'(src_data2)),
		.base           (ldst_pkg::address_t'(src_data3)),
		.issue_no       (cmd_issue_no),
		.dst            (cmd_dst),
		.data_push      (ld_mem.grant),		// One beat per grant
		.push_data      (ld_mem.rd_data),
		.data_pop       (ld_pop),
		.data_avail     (ld_avail),
		.pop_data       (ld_pop_data),
		.mem            (ld_mem),
		.token_grant    (commit_grant & ~sel_st),
		.token_valid    (ld_tok_valid),
		.token_issue_no (ld_tok_issue_no),
		.token_dst      (ld_tok_dst),
		.stall          (ld_stall)
	);

	ldst_channel st_channel (
		.clock          (clock),
		.rst_n          (rst_n),
		.accept         (st_accept),
		.len            (ldst_pkg::address_t'(src_data1)),
		.stride         (ldst_pkg::address_t'(src_data2)),
		.base           (ldst_pkg::address_t'(src_data3)),
		.issue_no       (cmd_issue_no),
		.dst            (cmd_dst),
		.data_push      (st_push),
		.push_data      (st_push_data),
		.data_pop       (st_mem.grant),		// Memory takes the head word
		.data_avail     (),
		.pop_data       (),
		.mem            (st_mem),
		.token_grant    (commit_grant & sel_st),
		.token_valid    (st_tok_valid),
		.token_issue_no (st_tok_issue_no),
		.token_dst      (st_tok_dst),
		.stall          (st_stall)
	);

	////////////////////
	// Write-back
	assign ld_pop = ld_avail & ~I_stall;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= ld_pop;
	end

	always_ff @(posedge clock) begin
		if (ld_pop)
			wb_data <= ld_pop_data;
	end

	////////////////////
	// Commit select
	// Age counts back from the current issue number, so wrap is harmless
	assign ld_age = cur_issue_no - ld_tok_issue_no;
	assign st_age = cur_issue_no - st_tok_issue_no;
	assign sel_st = st_tok_valid & (~ld_tok_valid | (st_age > ld_age));

	assign commit_valid    = ld_tok_valid | st_tok_valid;
	assign commit_issue_no = sel_st ? st_tok_issue_no : ld_tok_issue_no;
	assign commit_dst      = sel_st ? st_tok_dst : ld_tok_dst;
	assign commit_is_store = sel_st;

endmodule

`default_nettype wire

// ==== vector_ldst_unit.f ====
hdl/ldst_pkg.sv
hdl/mem_port_if.sv
hdl/ldst_channel.sv
hdl/vector_ldst_unit.sv
bench/tb_clock_gen.sv
bench/ldst_asserts.sv
bench/ldst_checker.sv
bench/tb_vector_ldst_unit.sv
